// ==== common/side_ch_defines.svh ====
// width, depth and subcarrier mask macros for the side channel blocks
`ifndef SIDE_CH_DEFINES_SVH
`define SIDE_CH_DEFINES_SVH

`define IQ_W 16
// signed, half dB steps
`define RSSI_W 11
// top bit agc lock, rest is gain
`define GPIO_W 8
`define TSF_W 64
`define DMA_W 64
`define DMA_CNT_W 14
`define DMA_DEPTH 256
`define IQ_AW 6
`define CSI_WORDS 64
`define CSI_HDR 2
`define CSI_USED 56
// bit 0 is DC, bits 29 to 35 are the band edge nulls
`define SUBC_MASK 64'hFFFF_FFF0_1FFF_FFFE

`endif

// ==== common/side_ch_pkg.sv ====
// shared types: IQ sample, status word, buffer word union, DMA request and word, trigger select
`include "side_ch_defines.svh"

package side_ch_pkg;

	typedef struct packed {
		logic signed [`IQ_W-1:0] i;
		logic signed [`IQ_W-1:0] q;
	} iq_sample_t;

	typedef struct packed {
		logic [15-`RSSI_W:0]       rssi_pad;
		logic signed [`RSSI_W-1:0] rssi;
		logic [15-`GPIO_W:0]       gpio_pad;
		logic [`GPIO_W-1:0]        gpio;
		iq_sample_t                iq;
	} status_word_t;

	// one ring buffer word, status record or two samples
	typedef union packed {
		status_word_t     status;
		iq_sample_t [1:0] pair; // pair[0] from iq0
	} iq_buf_word_u;

	typedef struct packed {
		logic                  req; // one cycle pulse
		logic [`DMA_CNT_W-1:0] len;
	} dma_req_t;

	typedef struct packed {
		logic              valid;
		logic [`DMA_W-1:0] data;
	} dma_word_t;

	typedef enum logic [2:0] {
		FCS_ANY, FCS_OK, FCS_BAD, RSSI_UP, RSSI_DOWN, AGC_LOCK, GAIN_UP, FREE_RUN
	} trig_sel_e;

endpackage

// ==== csi/csi_fifo.sv ====
// first-word-fall-through FIFO for the CSI samples of one packet
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module csi_fifo (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    flush,
	input  logic                    wr_en,
	input  side_ch_pkg::iq_sample_t din,
	input  logic                    rd_en,
	output side_ch_pkg::iq_sample_t dout,
	output logic                    empty
);
	import side_ch_pkg::*;

	localparam int AW = $clog2(`CSI_WORDS);

	iq_sample_t mem [`CSI_WORDS];
	logic [AW:0] wr_ptr; // msb is the wrap bit
	logic [AW:0] rd_ptr;
	logic full;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign dout = mem[rd_ptr[AW-1:0]]; // head word visible without a read

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr[AW-1:0]] <= din;
	end

	always_ff @(posedge clk) begin
		if (!rstn || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rstn || flush)
		!(wr_en && full));
	a_no_underflow: assert property (@(posedge clk) disable iff (!rstn || flush)
		!(rd_en && empty));

endmodule

// ==== csi/csi_capture.sv ====
// CSI path: frame control filter, timestamp latch, CSI buffer and masked streamer
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module csi_capture (
	input  logic                    clk,
	input  logic                    rstn,
	input  logic                    enable,
	input  logic                    demod_ongoing,
	input  logic                    fc_valid,
	input  logic [15:0]             fc,
	input  logic [15:0]             fc_target,
	input  logic                    fc_match_en,
	input  logic [15:0]             pkt_len,
	input  logic                    header_strobe,
	input  logic [`TSF_W-1:0]       tsf,
	input  logic [31:0]             phase_offset,
	input  side_ch_pkg::iq_sample_t csi,
	input  logic                    csi_valid,
	input  logic                    grant,
	input  logic                    deny,
	output side_ch_pkg::dma_req_t   req,
	output side_ch_pkg::dma_word_t  word
);
	import side_ch_pkg::*;

	typedef enum logic [2:0] {ST_IDLE, ST_BURST, ST_GRANT, ST_HDR1, ST_CSI} state_e;

	state_e state;
	logic fc_valid_d;
	logic csi_valid_d;
	logic demod_d;
	logic req_q;
	logic word_vld;
	logic [`DMA_W-1:0] word_dat;
	logic [`TSF_W-1:0] tsf_lat;
	logic [`CSI_WORDS-1:0] mask;
	logic [$clog2(`CSI_WORDS)-1:0] rd_cnt;
	logic fifo_rd;
	logic fifo_empty;
	iq_sample_t fifo_dout;
	logic fc_rise;
	logic csi_fall;
	logic pkt_start;

	assign fc_rise = fc_valid && !fc_valid_d;
	assign csi_fall = !csi_valid && csi_valid_d;
	assign pkt_start = demod_ongoing && !demod_d;
	assign fifo_rd = (state == ST_CSI) && !fifo_empty;
	assign req = '{req: req_q, len: `DMA_CNT_W'(`CSI_HDR + `CSI_USED)};
	assign word = '{valid: word_vld, data: word_dat};

	csi_fifo fifo_i (
		.clk, .rstn,
		.flush(pkt_start || !enable), .wr_en(enable && csi_valid), .din(csi),
		.rd_en(fifo_rd), .dout(fifo_dout), .empty(fifo_empty)
	);

	always_ff @(posedge clk) begin
		if (header_strobe)
			tsf_lat <= tsf;
		case (state)
			ST_GRANT: word_dat <= tsf_lat;
			ST_HDR1: word_dat <= {32'd0, phase_offset};
			ST_CSI: word_dat <= {32'd0, fifo_dout};
			default: word_dat <= word_dat;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn || !enable) begin
			state <= ST_IDLE;
			fc_valid_d <= 1'b0;
			csi_valid_d <= 1'b0;
			demod_d <= 1'b0;
			req_q <= 1'b0;
			word_vld <= 1'b0;
			mask <= `SUBC_MASK;
			rd_cnt <= '0;
		end else begin
			fc_valid_d <= fc_valid;
			csi_valid_d <= csi_valid;
			demod_d <= demod_ongoing;
			req_q <= 1'b0;
			case (state)
				ST_IDLE: begin
					word_vld <= 1'b0;
					mask <= `SUBC_MASK;
					rd_cnt <= '0;
					if (fc_rise && (fc == fc_target || !fc_match_en) && pkt_len >= 16'd14)
						state <= ST_BURST;
				end
				ST_BURST: begin
					if (csi_fall) begin // burst over, ask for room
						req_q <= 1'b1;
						state <= ST_GRANT;
					end
				end
				ST_GRANT: begin
					if (grant) begin
						word_vld <= 1'b1;
						state <= ST_HDR1;
					end else if (deny) begin
						state <= ST_IDLE;
					end
				end
				ST_HDR1: state <= ST_CSI;
				ST_CSI: begin
					word_vld <= mask[0]; // nulls and DC are read but not sent
					mask <= {mask[0], mask[`CSI_WORDS-1:1]};
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == '1)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_grant_after_req: assert property (@(posedge clk) disable iff (!rstn)
		grant |-> $past(req_q));

endmodule

// ==== iq/iq_trigger.sv ====
// IQ trigger: RSSI and gain crossing detectors and registered trigger select
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module iq_trigger (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      enable,
	input  side_ch_pkg::trig_sel_e    sel,
	input  logic signed [`RSSI_W-1:0] rssi_half_db,
	input  logic signed [`RSSI_W-1:0] rssi_th,
	input  logic [`GPIO_W-1:0]        gpio_status,
	input  logic [`GPIO_W-2:0]        gain_th,
	input  logic                      fcs_strobe,
	input  logic                      fcs_ok,
	output logic                      trigger
);
	import side_ch_pkg::*;

	logic signed [`RSSI_W-1:0] rssi_d;
	logic [`GPIO_W-1:0] gpio_d;
	logic rssi_up;
	logic rssi_down;
	logic agc_lock;
	logic gain_up;
	logic event_sel;

	assign rssi_up = (rssi_d < rssi_th) && (rssi_half_db >= rssi_th);
	assign rssi_down = (rssi_d >= rssi_th) && (rssi_half_db < rssi_th);
	assign agc_lock = gpio_status[`GPIO_W-1] && !gpio_d[`GPIO_W-1]; // unlock to lock
	assign gain_up = (gpio_status[`GPIO_W-2:0] >= gain_th) && (gpio_d[`GPIO_W-2:0] < gain_th);

	always_comb begin
		case (sel)
			FCS_ANY: event_sel = fcs_strobe;
			FCS_OK: event_sel = fcs_strobe && fcs_ok;
			FCS_BAD: event_sel = fcs_strobe && !fcs_ok;
			RSSI_UP: event_sel = rssi_up;
			RSSI_DOWN: event_sel = rssi_down;
			AGC_LOCK: event_sel = agc_lock;
			GAIN_UP: event_sel = gain_up;
			FREE_RUN: event_sel = fcs_strobe || enable; // capture side drops it while busy
			default: event_sel = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rssi_d <= '0;
			gpio_d <= '0;
			trigger <= 1'b0;
		end else begin
			rssi_d <= rssi_half_db;
			gpio_d <= gpio_status;
			trigger <= enable && event_sel;
		end
	end

endmodule

// ==== iq/iq_capture.sv ====
// IQ path: ring buffer of sample words and the pre-trigger readout sequencer
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module iq_capture (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      enable,
	input  side_ch_pkg::iq_sample_t   iq0,
	input  side_ch_pkg::iq_sample_t   iq1,
	input  logic                      iq_strobe,
	input  logic                      status_view,
	input  logic signed [`RSSI_W-1:0] rssi_half_db,
	input  logic [`GPIO_W-1:0]        gpio_status,
	input  logic [`TSF_W-1:0]         tsf,
	input  logic                      trigger,
	input  logic [`IQ_AW-1:0]         pre_len,
	input  logic [`IQ_AW-1:0]         iq_len,
	input  logic                      grant,
	input  logic                      deny,
	output side_ch_pkg::dma_req_t     req,
	output side_ch_pkg::dma_word_t    word
);
	import side_ch_pkg::*;

	typedef enum logic [1:0] {ST_WAIT, ST_GRANT, ST_DATA} state_e;

	state_e state;
	iq_buf_word_u ring [2**`IQ_AW];
	iq_buf_word_u wr_word;
	logic [`IQ_AW-1:0] waddr;
	logic [`IQ_AW-1:0] raddr;
	logic [`IQ_AW-1:0] cnt;
	logic [`TSF_W-1:0] tsf_lat;
	logic req_q;
	logic word_vld;
	logic [`DMA_W-1:0] word_dat;

	assign req = '{req: req_q, len: `DMA_CNT_W'(iq_len) + 1'b1}; // timestamp plus samples
	assign word = '{valid: word_vld, data: word_dat};

	always_comb begin
		wr_word = '0;
		if (status_view) begin
			wr_word.status.rssi = rssi_half_db;
			wr_word.status.gpio = gpio_status;
			wr_word.status.iq = iq0;
		end else begin
			wr_word.pair[1] = iq1;
			wr_word.pair[0] = iq0;
		end
	end

	always_ff @(posedge clk) begin
		if (enable && iq_strobe)
			ring[waddr] <= wr_word;
		if (state == ST_WAIT && trigger)
			tsf_lat <= tsf;
		if (state == ST_GRANT)
			word_dat <= tsf_lat;
		else
			word_dat <= ring[raddr];
	end

	always_ff @(posedge clk) begin
		if (!rstn || !enable) begin
			state <= ST_WAIT;
			waddr <= '0;
			raddr <= '0;
			cnt <= '0;
			req_q <= 1'b0;
			word_vld <= 1'b0;
		end else begin
			req_q <= 1'b0;
			word_vld <= 1'b0;
			if (iq_strobe)
				waddr <= waddr + 1'b1;
			case (state)
				ST_WAIT: begin
					if (trigger) begin
						raddr <= waddr - pre_len; // reach back before the trigger
						cnt <= '0;
						req_q <= 1'b1;
						state <= ST_GRANT;
					end
				end
				ST_GRANT: begin
					if (grant) begin
						word_vld <= 1'b1;
						state <= (iq_len == '0) ? ST_WAIT : ST_DATA;
					end else if (deny) begin
						state <= ST_WAIT;
					end
				end
				ST_DATA: begin
					if (iq_strobe) begin // read pace follows the write pace
						word_vld <= 1'b1;
						raddr <= raddr + 1'b1;
						cnt <= cnt + 1'b1;
						if (cnt == iq_len - 1'b1)
							state <= ST_WAIT;
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// window settings must not move under a capture in flight
	a_window_stable: assert property (@(posedge clk) disable iff (!rstn || !enable)
		(state != ST_WAIT) |-> $stable(pre_len) && $stable(iq_len));

endmodule

// ==== src/dma_arbiter.sv ====
// DMA admission with room check, grant and deny pulses and the registered output word
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module dma_arbiter (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   iq_mode,
	input  logic [`DMA_CNT_W-1:0]  m_axis_data_count,
	input  side_ch_pkg::dma_req_t  csi_req,
	input  side_ch_pkg::dma_req_t  iq_req,
	input  side_ch_pkg::dma_word_t csi_word,
	input  side_ch_pkg::dma_word_t iq_word,
	output logic                   csi_grant,
	output logic                   csi_deny,
	output logic                   iq_grant,
	output logic                   iq_deny,
	output logic [`DMA_W-1:0]      data_to_ps,
	output logic                   data_to_ps_valid
);
	logic csi_ok;
	logic iq_ok;

	// sum is 32 bits wide so a count past the depth cannot wrap
	assign csi_ok = !iq_mode && (m_axis_data_count + csi_req.len <= `DMA_DEPTH);
	assign iq_ok = iq_mode && (m_axis_data_count + iq_req.len <= `DMA_DEPTH);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			csi_grant <= 1'b0;
			csi_deny <= 1'b0;
			iq_grant <= 1'b0;
			iq_deny <= 1'b0;
			data_to_ps_valid <= 1'b0;
		end else begin
			csi_grant <= csi_req.req && csi_ok;
			csi_deny <= csi_req.req && !csi_ok;
			iq_grant <= iq_req.req && iq_ok;
			iq_deny <= iq_req.req && !iq_ok;
			data_to_ps_valid <= iq_mode ? iq_word.valid : csi_word.valid;
		end
	end

	always_ff @(posedge clk) begin
		data_to_ps <= iq_mode ? iq_word.data : csi_word.data;
	end

	// the disabled path is held idle and never asks
	a_mode_req: assert property (@(posedge clk) disable iff (!rstn)
		(csi_req.req |-> !iq_mode) and (iq_req.req |-> iq_mode));

endmodule

// ==== src/side_ch_control.sv ====
// side channel top: CSI and IQ capture paths, IQ trigger and DMA arbiter
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module side_ch_control (
	input  logic                      clk,
	input  logic                      rstn,
	input  logic                      iq_capture, // mode, high selects the IQ path
	input  logic                      demod_ongoing, fc_valid, fc_match_en,
	input  logic                      header_strobe, csi_valid,
	input  logic [15:0]               fc, fc_target, pkt_len,
	input  logic [`TSF_W-1:0]         tsf,
	input  logic [31:0]               phase_offset,
	input  side_ch_pkg::iq_sample_t   csi, iq0, iq1,
	input  logic                      iq_strobe, status_view, fcs_strobe, fcs_ok,
	input  side_ch_pkg::trig_sel_e    trig_sel,
	input  logic signed [`RSSI_W-1:0] rssi_half_db, rssi_th,
	input  logic [`GPIO_W-1:0]        gpio_status,
	input  logic [`GPIO_W-2:0]        gain_th,
	input  logic [`IQ_AW-1:0]         pre_len, iq_len,
	input  logic [`DMA_CNT_W-1:0]     m_axis_data_count,
	output logic [`DMA_W-1:0]         data_to_ps,
	output logic                      data_to_ps_valid
);
	import side_ch_pkg::*;

	dma_req_t csi_req;
	dma_req_t iq_req;
	dma_word_t csi_word;
	dma_word_t iq_word;
	logic csi_grant;
	logic csi_deny;
	logic iq_grant;
	logic iq_deny;
	logic trigger;

	csi_capture csi_i (
		.clk, .rstn, .enable(!iq_capture),
		.demod_ongoing, .fc_valid, .fc, .fc_target, .fc_match_en, .pkt_len,
		.header_strobe, .tsf, .phase_offset, .csi, .csi_valid,
		.grant(csi_grant), .deny(csi_deny), .req(csi_req), .word(csi_word)
	);

	iq_trigger trig_i (
		.clk, .rstn, .enable(iq_capture), .sel(trig_sel),
		.rssi_half_db, .rssi_th, .gpio_status, .gain_th, .fcs_strobe, .fcs_ok,
		.trigger
	);

	iq_capture iq_i (
		.clk, .rstn, .enable(iq_capture),
		.iq0, .iq1, .iq_strobe, .status_view, .rssi_half_db, .gpio_status, .tsf,
		.trigger, .pre_len, .iq_len,
		.grant(iq_grant), .deny(iq_deny), .req(iq_req), .word(iq_word)
	);

	dma_arbiter arb_i (
		.clk, .rstn, .iq_mode(iq_capture), .m_axis_data_count,
		.csi_req, .iq_req, .csi_word, .iq_word,
		.csi_grant, .csi_deny, .iq_grant, .iq_deny,
		.data_to_ps, .data_to_ps_valid
	);

endmodule

// ==== test/tb_side_ch.sv ====
// testbench for the side channel top with scenario table, IQ ring model and DMA word checks
`timescale 1ns/1ns
`include "side_ch_defines.svh"

module tb_side_ch;
	import side_ch_pkg::*;

	typedef struct packed {
		logic                  iq_mode;
		trig_sel_e             sel;
		logic                  match_en;
		logic [15:0]           fc;
		logic [`DMA_CNT_W-1:0] dma_cnt;
		logic [`IQ_AW-1:0]     pre_len;
		logic [`IQ_AW-1:0]     iq_len;
		logic [7:0]            exp_words;
	} row_t;

	localparam int ROWS = 10;
	localparam logic [15:0] FC_TARGET = 16'h0088;
	localparam int RSSI_TH = -120; // -60 dBm

	logic clk = 1'b0;
	logic rstn, iq_capture, demod_ongoing, fc_valid, fc_match_en, header_strobe, csi_valid;
	logic [15:0] fc, fc_target, pkt_len;
	logic [`TSF_W-1:0] tsf;
	logic [31:0] phase_offset;
	iq_sample_t csi, iq0, iq1;
	logic iq_strobe, status_view, fcs_strobe, fcs_ok;
	trig_sel_e trig_sel;
	logic signed [`RSSI_W-1:0] rssi_half_db, rssi_th;
	logic [`GPIO_W-1:0] gpio_status;
	logic [`GPIO_W-2:0] gain_th;
	logic [`IQ_AW-1:0] pre_len, iq_len;
	logic [`DMA_CNT_W-1:0] m_axis_data_count;
	logic [`DMA_W-1:0] data_to_ps;
	logic data_to_ps_valid;

	row_t tab [ROWS];
	logic [31:0] lcg_state = 32'hf51e;
	logic [`TSF_W-1:0] tsf_now; // value the DUT sees at the next edge
	int rssi_base;
	int err_cnt;
	logic [`DMA_W-1:0] rx [$];
	logic [`DMA_W-1:0] exp_q [$];
	iq_buf_word_u hist [$]; // every word written since the IQ path was enabled

	side_ch_control dut_i (
		.clk, .rstn, .iq_capture, .demod_ongoing, .fc_valid, .fc_match_en,
		.header_strobe, .csi_valid, .fc, .fc_target, .pkt_len, .tsf, .phase_offset,
		.csi, .iq0, .iq1, .iq_strobe, .status_view, .fcs_strobe, .fcs_ok, .trig_sel,
		.rssi_half_db, .rssi_th, .gpio_status, .gain_th, .pre_len, .iq_len,
		.m_axis_data_count, .data_to_ps, .data_to_ps_valid
	);

	always #10 clk = ~clk;

	always @(negedge clk) begin
		if (rstn && data_to_ps_valid)
			rx.push_back(data_to_ps);
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// ring model at negedge then fresh samples and tsf on the rising edge
	task automatic tick();
		iq_buf_word_u w;
		logic [31:0] r;
		@(negedge clk);
		w = '0;
		if (status_view) begin
			w.status.rssi = rssi_half_db;
			w.status.gpio = gpio_status;
			w.status.iq = iq0;
		end else begin
			w.pair[0] = iq0;
			w.pair[1] = iq1;
		end
		if (!rstn || !iq_capture)
			hist.delete();
		else if (iq_strobe)
			hist.push_back(w);
		@(posedge clk);
		tsf_now = tsf_now + 1'b1;
		tsf <= tsf_now;
		iq0 <= lcg_next();
		iq1 <= lcg_next();
		r = lcg_next();
		gpio_status <= r[31:24];
		rssi_half_db <= `RSSI_W'(rssi_base + int'(r[2:0])); // small jitter
	endtask

	task automatic await_words(input int n);
		int waited;
		waited = 0;
		while (rx.size() < n && waited < 300) begin
			tick();
			waited++;
		end
		repeat (40) tick(); // stray extra words would land here
	endtask

	task automatic load_table();
		// mode, select, match, frame control, dma count, pre_len, iq_len, words
		tab[0] = '{1'b0, FCS_ANY, 1'b1, FC_TARGET, 14'd0, 6'd0, 6'd0, 8'd58};
		tab[1] = '{1'b0, FCS_ANY, 1'b1, 16'h0208, 14'd0, 6'd0, 6'd0, 8'd0};
		tab[2] = '{1'b0, FCS_ANY, 1'b0, 16'h00d4, 14'd0, 6'd0, 6'd0, 8'd58};
		tab[3] = '{1'b1, FCS_OK, 1'b0, 16'h0000, 14'd0, 6'd5, 6'd8, 8'd9};
		tab[4] = '{1'b1, FCS_OK, 1'b0, 16'h0000, 14'd250, 6'd20, 6'd30, 8'd0};
		tab[5] = '{1'b1, FCS_OK, 1'b0, 16'h0000, 14'd225, 6'd20, 6'd30, 8'd31};
		tab[6] = '{1'b1, RSSI_UP, 1'b0, 16'h0000, 14'd100, 6'd3, 6'd12, 8'd13};
		tab[7] = '{1'b0, FCS_ANY, 1'b1, FC_TARGET, 14'd200, 6'd0, 6'd0, 8'd0};
		tab[8] = '{1'b0, FCS_ANY, 1'b1, FC_TARGET, 14'd198, 6'd0, 6'd0, 8'd58};
		tab[9] = '{1'b1, FCS_OK, 1'b0, 16'h0000, 14'd0, 6'd0, 6'd4, 8'd5};
	endtask

	task automatic run_csi_row(input row_t r);
		logic [`CSI_WORDS-1:0] mask_bits;
		logic [31:0] smp;
		int k;
		mask_bits = `SUBC_MASK;
		rx.delete();
		exp_q.delete();
		iq_capture <= 1'b0;
		fc_match_en <= r.match_en;
		fc <= r.fc;
		m_axis_data_count <= r.dma_cnt;
		phase_offset <= lcg_next();
		repeat (4) tick();
		demod_ongoing <= 1'b1;
		tick();
		fc_valid <= 1'b1;
		tick();
		fc_valid <= 1'b0;
		header_strobe <= 1'b1;
		exp_q.push_back(tsf_now);
		exp_q.push_back({32'd0, phase_offset});
		tick();
		header_strobe <= 1'b0;
		for (k = 0; k < `CSI_WORDS; k++) begin
			smp = lcg_next();
			csi <= smp;
			csi_valid <= 1'b1;
			if (mask_bits[k])
				exp_q.push_back({32'd0, smp});
			tick();
		end
		csi_valid <= 1'b0;
		demod_ongoing <= 1'b0;
		await_words(r.exp_words);
		check_eq(64'(rx.size()), 64'(r.exp_words), "csi word count");
		if (r.exp_words != 0) begin
			foreach (exp_q[m])
				check_eq(rx[m], exp_q[m], $sformatf("csi word %0d", m));
		end
	endtask

	task automatic run_iq_row(input row_t r);
		int start;
		int m;
		logic [`TSF_W-1:0] exp_ts;
		iq_buf_word_u got;
		iq_buf_word_u want;
		rx.delete();
		iq_capture <= 1'b1;
		trig_sel <= r.sel;
		status_view <= (r.sel == RSSI_UP);
		pre_len <= r.pre_len;
		iq_len <= r.iq_len;
		m_axis_data_count <= r.dma_cnt;
		rssi_base = RSSI_TH + 30;
		repeat (70) tick(); // more than one lap of the ring
		if (r.sel == RSSI_UP) begin
			rssi_base = RSSI_TH - 30; // downward step only
		end else begin
			fcs_strobe <= 1'b1;
			fcs_ok <= 1'b0;
		end
		tick();
		fcs_strobe <= 1'b0;
		repeat (12) tick();
		check_eq(64'(rx.size()), 64'd0, "capture on an event that is not selected");
		if (r.sel == RSSI_UP) begin
			rssi_base = RSSI_TH + 30;
			rssi_half_db <= `RSSI_W'(rssi_base);
		end else begin
			fcs_strobe <= 1'b1;
			fcs_ok <= 1'b1;
		end
		tick();
		fcs_strobe <= 1'b0;
		fcs_ok <= 1'b0;
		// event seen one edge ago so the trigger lands on the coming edge
		start = hist.size() - int'(r.pre_len);
		exp_ts = tsf_now;
		await_words(r.exp_words);
		check_eq(64'(rx.size()), 64'(r.exp_words), "iq word count");
		if (r.exp_words != 0) begin
			check_eq(rx[0], exp_ts, "iq trigger timestamp");
			for (m = 0; m < int'(r.iq_len); m++) begin
				got = rx[m + 1];
				want = hist[start + m];
				if (r.sel == RSSI_UP) begin
					check_eq(64'(got.status.rssi), 64'(want.status.rssi), "decoded rssi");
					check_eq(64'(got.status.gpio), 64'(want.status.gpio), "decoded gain status");
				end
				check_eq(got, want, $sformatf("iq word %0d", m));
			end
		end
	endtask

	initial begin
		int n;
		err_cnt = 0;
		load_table();
		tsf_now[63:32] = lcg_next();
		tsf_now[31:0] = lcg_next();
		rssi_base = RSSI_TH + 30;
		rstn <= 1'b0;
		iq_capture <= 1'b0;
		demod_ongoing <= 1'b0;
		fc_valid <= 1'b0;
		fc_match_en <= 1'b0;
		header_strobe <= 1'b0;
		csi_valid <= 1'b0;
		fc <= '0;
		fc_target <= FC_TARGET;
		pkt_len <= 16'd100;
		tsf <= tsf_now;
		phase_offset <= '0;
		csi <= '0;
		iq0 <= '0;
		iq1 <= '0;
		iq_strobe <= 1'b1; // samples every cycle
		status_view <= 1'b0;
		fcs_strobe <= 1'b0;
		fcs_ok <= 1'b0;
		trig_sel <= FCS_ANY;
		rssi_half_db <= '0;
		rssi_th <= `RSSI_W'(RSSI_TH);
		gpio_status <= '0;
		gain_th <= 7'd40;
		pre_len <= '0;
		iq_len <= '0;
		m_axis_data_count <= '0;
		repeat (2) @(posedge clk);
		rstn <= 1'b1;
		repeat (10) tick();
		check_eq(64'(rx.size()), 64'd0, "valid word before any capture");
		for (n = 0; n < ROWS; n++) begin
			if (tab[n].iq_mode)
				run_iq_row(tab[n]);
			else
				run_csi_row(tab[n]);
		end
		if (err_cnt == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "checks failed");
		end
	end

	initial begin
		repeat (ROWS * 400) @(posedge clk);
		$display("timeout: the scenario table did not finish within %0d cycles", ROWS * 400);
		$display("TEST FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

// ==== side_ch.f ====
+incdir+common
common/side_ch_pkg.sv
csi/csi_fifo.sv
csi/csi_capture.sv
iq/iq_trigger.sv
iq/iq_capture.sv
src/dma_arbiter.sv
src/side_ch_control.sv
test/tb_side_ch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the side channel testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_side_ch \
	-f side_ch.f -o sim_side_ch

./obj_dir/sim_side_ch > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"
